/* accelCntPkg.sv */
package accelCntPkg;

	////////////////////////////////
	// configuration and status
	////////////////////////////////

	typedef struct packed {
		logic [3:0] refPeriod; // last refresh timer value
		logic [3:0] urgStart; // first urgent timer value
		logic [3:0] qosLen; // QoS hold in timer ticks
		logic [1:0] sndQosLen; // sound QoS hold
		logic [11:0] lTimerLen; // last long timer value
	} cfgT;

	typedef struct packed {
		logic [1:0] startState;
		logic refReq;
		logic refUrg;
		logic qosEn;
		logic sndQosReady;
		logic nResOut;
		logic clkOk;
	} statusT;

	typedef struct packed {
		logic eFall; // one cycle pulse
		logic clkOk; // C8M seen toggling
		logic nIpl2;
		logic nResIn;
	} syncT;

	typedef struct packed {
		logic timerTick; // refresh timer wrap
		logic lTimerTick; // long timer wrap
	} tickT;

	////////////////////////////////
	// AXI4-Lite
	////////////////////////////////

	typedef struct packed {
		logic [3:0] awaddr;
		logic awvalid;
		logic [31:0] wdata;
		logic [3:0] wstrb;
		logic wvalid;
		logic bready;
		logic [3:0] araddr;
		logic arvalid;
		logic rready;
	} axiReqT;

	typedef struct packed {
		logic awready;
		logic wready;
		logic [1:0] bresp;
		logic bvalid;
		logic arready;
		logic [31:0] rdata;
		logic [1:0] rresp;
		logic rvalid;
	} axiRspT;

	localparam logic [3:0] ADDR_REF = 4'h0; // refPeriod, urgStart
	localparam logic [3:0] ADDR_QOS = 4'h4; // qosLen, sndQosLen
	localparam logic [3:0] ADDR_LTIM = 4'h8; // lTimerLen
	localparam logic [3:0] ADDR_STAT = 4'hC; // read only

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	localparam cfgT CFG_DEFAULT = '{
		refPeriod: 4'd10, // 11 states per refresh
		urgStart: 4'd8,
		qosLen: 4'd15,
		sndQosLen: 2'd3,
		lTimerLen: 12'd4095
	};

endpackage

/* syncEdge.sv */
`timescale 1ns/1ps

module syncEdge import accelCntPkg::*; (
	input  logic CLK,
	input  logic rstN,
	input  logic e,
	input  logic c8m,
	input  logic nIpl2,
	input  logic nResIn,
	output syncT sync
);

	logic [2:0] eSync; // two sync flops plus one of history
	logic [1:0] c8mSync;
	logic [3:0] c8mHist; // bit 0 newest
	logic [1:0] nIplSync;
	logic [1:0] nResSync;
	logic eFallQ;
	logic clkOkQ;

	////////////////////////////////
	// pin synchronizers
	////////////////////////////////

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			eSync <= '0;
			c8mSync <= '0;
			c8mHist <= '0;
			nIplSync <= '1; // active low lines idle high
			nResSync <= '1;
		end else begin
			eSync <= {eSync[1:0], e};
			c8mSync <= {c8mSync[0], c8m};
			c8mHist <= {c8mHist[2:0], c8mSync[1]};
			nIplSync <= {nIplSync[0], nIpl2};
			nResSync <= {nResSync[0], nResIn};
		end
	end

	////////////////////////////////
	// E edge and C8M activity
	////////////////////////////////

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			eFallQ <= 1'b0;
			clkOkQ <= 1'b0; // no clock seen yet
		end else begin
			eFallQ <= eSync[2] && !eSync[1]; // old high, new low
			if (c8mHist == 4'b0000 || c8mHist == 4'b1111)
				clkOkQ <= 1'b0; // stuck for four samples
			else if (c8mHist[1:0] == 2'b01)
				clkOkQ <= 1'b1; // rising edge
		end
	end

	assign sync = '{
		eFall: eFallQ,
		clkOk: clkOkQ,
		nIpl2: nIplSync[1],
		nResIn: nResSync[1]
	};

endmodule

/* refreshTimer.sv */
`timescale 1ns/1ps

module refreshTimer import accelCntPkg::*; #(
	parameter int TimerWidth = 4,
	parameter int LTimerWidth = 12
) (
	input  logic CLK,
	input  logic rstN,
	input  syncT sync,
	input  cfgT cfg,
	output logic refReq,
	output logic refUrg,
	output tickT tick
);

	logic [TimerWidth-1:0] timer;
	logic [TimerWidth-1:0] refPeriod; // cfg widened to the counter
	logic [TimerWidth-1:0] urgStart;
	logic timerTc;
	logic [LTimerWidth-1:0] lTimer;
	logic [LTimerWidth-1:0] lTimerLen;
	logic lTimerTc;

	assign refPeriod = TimerWidth'(cfg.refPeriod);
	assign urgStart = TimerWidth'(cfg.urgStart);
	assign lTimerLen = LTimerWidth'(cfg.lTimerLen);
	assign timerTc = timer == refPeriod; // last step of the period
	assign lTimerTc = lTimer == lTimerLen;

	////////////////////////////////
	// refresh timer on E falls
	////////////////////////////////

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			timer <= '0;
			refReq <= 1'b0;
			refUrg <= 1'b0;
		end else if (sync.eFall) begin
			timer <= timerTc ? '0 : timer + 1'b1; // wrap after refPeriod
			refReq <= !timerTc; // one idle step per period
			refUrg <= (timer >= urgStart) && (timer < refPeriod);
		end
	end

	////////////////////////////////
	// long timer prescaler
	////////////////////////////////

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			lTimer <= '0;
			tick <= '0;
		end else begin
			if (tick.timerTick)
				lTimer <= lTimerTc ? '0 : lTimer + 1'b1;
			tick.timerTick <= sync.eFall && timerTc; // one per refresh period
			tick.lTimerTick <= tick.timerTick && lTimerTc;
		end
	end

endmodule

/* qosTimer.sv */
`timescale 1ns/1ps

module qosTimer import accelCntPkg::*; #(
	parameter int TimerWidth = 4
) (
	input  logic CLK,
	input  logic rstN,
	input  syncT sync,
	input  tickT tick,
	input  cfgT cfg,
	input  logic bact,
	input  logic qosCs,
	input  logic sndQosCs,
	output logic qosEn,
	output logic sndQosReady
);

	logic selQ; // any select or reset button held
	logic selSnd; // sound select only
	logic [TimerWidth-1:0] qosCnt;
	logic [TimerWidth-1:0] sndCnt;
	logic [3:0] waitCnt; // bus cycle length

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			selQ <= 1'b0;
			selSnd <= 1'b0;
		end else begin
			selQ <= (bact && (qosCs || sndQosCs)) || !sync.nResIn;
			selSnd <= bact && sndQosCs;
		end
	end

	////////////////////////////////
	// hold-off counters
	////////////////////////////////

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN)
			qosCnt <= '0;
		else if (selQ)
			qosCnt <= TimerWidth'(cfg.qosLen); // restart hold
		else if (tick.timerTick && qosCnt != '0)
			qosCnt <= qosCnt - 1'b1; // stops at zero
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN)
			sndCnt <= '0;
		else if (selSnd)
			sndCnt <= TimerWidth'(cfg.sndQosLen);
		else if (selQ)
			sndCnt <= '0; // plain access ends sound hold
		else if (tick.timerTick && sndCnt != '0)
			sndCnt <= sndCnt - 1'b1;
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN)
			waitCnt <= '0;
		else if (!bact)
			waitCnt <= '0;
		else
			waitCnt <= waitCnt + 1'b1; // counts bus cycle clocks
	end

	////////////////////////////////
	// outputs, updated between accesses
	////////////////////////////////

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			qosEn <= 1'b0;
			sndQosReady <= 1'b1;
		end else begin
			if (!bact)
				qosEn <= qosCnt != '0;
			if (!bact)
				sndQosReady <= sndCnt == '0;
			else if (selQ && !selSnd)
				sndQosReady <= 1'b1; // plain access
			else if (waitCnt == 4'd15)
				sndQosReady <= 1'b1; // long wait gives up
		end
	end

endmodule

/* startupCtrl.sv */
`timescale 1ns/1ps

module startupCtrl import accelCntPkg::*; (
	input  logic CLK,
	input  logic rstN,
	input  syncT sync,
	input  tickT tick,
	output logic [1:0] startState,
	output logic nResOut,
	output logic aoutOe,
	output logic nBrIob
);

	typedef enum logic [1:0] {HOLD0, HOLD1, ARB, RUN} stateT;

	stateT state;

	assign startState = state;

	////////////////////////////////
	// power-up sequence
	////////////////////////////////

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN)
			state <= HOLD0;
		else if (!sync.clkOk)
			state <= HOLD0; // C8M stuck or absent
		else begin
			case (state)
				HOLD0: if (tick.lTimerTick) state <= HOLD1;
				HOLD1: if (tick.lTimerTick) state <= ARB;
				ARB: if (tick.lTimerTick && sync.nIpl2) state <= RUN; // wait out NMI
				default: state <= RUN; // stays running
			endcase
		end
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			nResOut <= 1'b0;
			aoutOe <= 1'b0;
			nBrIob <= 1'b0;
		end else begin
			case (state)
				HOLD0, HOLD1: begin
					nResOut <= 1'b0; // reset held
					aoutOe <= 1'b0; // PDS address and control tristated
					nBrIob <= 1'b0; // bus requested
				end
				ARB: begin
					nResOut <= 1'b0;
					aoutOe <= 1'b0;
					if (!sync.nIpl2)
						nBrIob <= 1'b1; // NMI drops the bus request
				end
				default: begin
					aoutOe <= !nBrIob; // drive only with bus granted
					if (tick.lTimerTick)
						nResOut <= 1'b1; // release one long tick later
				end
			endcase
		end
	end

endmodule

/* cfgRegs.sv */
`timescale 1ns/1ps

module cfgRegs import accelCntPkg::*; #(
	parameter int TimerWidth = 4,
	parameter int LTimerWidth = 12
) (
	input  logic CLK,
	input  logic rstN,
	input  axiReqT axiReq,
	output axiRspT axiRsp,
	input  statusT status,
	output cfgT cfg
);

	// writable bits limited to the counter widths
	localparam logic [3:0] TMask = (TimerWidth >= 4) ? 4'hF : 4'((1 << TimerWidth) - 1);
	localparam logic [11:0] LMask =
		(LTimerWidth >= 12) ? 12'hFFF : 12'((1 << LTimerWidth) - 1);

	typedef enum logic {W_IDLE, W_RESP} wStateT;
	typedef enum logic {R_IDLE, R_RESP} rStateT;

	wStateT wState;
	rStateT rState;
	logic wAccept; // write handshake cycle
	logic rAccept; // read handshake cycle
	logic wAddrOk;
	logic [1:0] bresp;
	logic [1:0] rresp;
	logic [31:0] rdata;

	assign wAccept = (wState == W_IDLE) && axiReq.awvalid && axiReq.wvalid;
	assign rAccept = (rState == R_IDLE) && axiReq.arvalid;
	assign wAddrOk = axiReq.awaddr inside {ADDR_REF, ADDR_QOS, ADDR_LTIM};

	////////////////////////////////
	// write channel
	////////////////////////////////

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			wState <= W_IDLE;
			bresp <= RESP_OKAY;
			cfg <= CFG_DEFAULT;
		end else begin
			case (wState)
				W_IDLE: if (wAccept) begin
					wState <= W_RESP;
					bresp <= wAddrOk ? RESP_OKAY : RESP_SLVERR; // status is read only
				end
				default: if (axiReq.bready) wState <= W_IDLE;
			endcase
			if (wAccept && axiReq.wstrb[0]) begin
				case (axiReq.awaddr)
					ADDR_REF: begin
						cfg.refPeriod <= axiReq.wdata[3:0] & TMask;
						cfg.urgStart <= axiReq.wdata[7:4] & TMask;
					end
					ADDR_QOS: begin
						cfg.qosLen <= axiReq.wdata[3:0] & TMask;
						cfg.sndQosLen <= axiReq.wdata[5:4] & TMask[1:0];
					end
					ADDR_LTIM: cfg.lTimerLen[7:0] <= axiReq.wdata[7:0] & LMask[7:0];
					default: ; // refused
				endcase
			end
			if (wAccept && axiReq.wstrb[1] && axiReq.awaddr == ADDR_LTIM)
				cfg.lTimerLen[11:8] <= axiReq.wdata[11:8] & LMask[11:8]; // upper byte
		end
	end

	////////////////////////////////
	// read channel
	////////////////////////////////

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			rState <= R_IDLE;
			rresp <= RESP_OKAY;
			rdata <= '0;
		end else begin
			case (rState)
				R_IDLE: if (rAccept) begin
					rState <= R_RESP;
					rresp <= RESP_OKAY;
					case (axiReq.araddr)
						ADDR_REF: rdata <= {24'd0, cfg.urgStart, cfg.refPeriod};
						ADDR_QOS: rdata <= {26'd0, cfg.sndQosLen, cfg.qosLen};
						ADDR_LTIM: rdata <= {20'd0, cfg.lTimerLen};
						ADDR_STAT: rdata <= {24'd0, status}; // live snapshot
						default: begin
							rdata <= '0;
							rresp <= RESP_SLVERR;
						end
					endcase
				end
				default: if (axiReq.rready) rState <= R_IDLE;
			endcase
		end
	end

	assign axiRsp = '{
		awready: wAccept,
		wready: wAccept, // both pulse together
		bresp: bresp,
		bvalid: wState == W_RESP,
		arready: rAccept,
		rdata: rdata,
		rresp: rresp,
		rvalid: rState == R_RESP
	};

endmodule

/* accelCnt.sv */
`timescale 1ns/1ps

module accelCnt import accelCntPkg::*; #(
	parameter int TimerWidth = 4,
	parameter int LTimerWidth = 12
) (
	input  logic CLK,
	input  logic rstN,
	input  logic e,
	input  logic c8m,
	input  logic nIpl2,
	input  logic nResIn,
	input  logic bact,
	input  logic qosCs,
	input  logic sndQosCs,
	input  axiReqT axiReq,
	output axiRspT axiRsp,
	output logic refReq,
	output logic refUrg,
	output logic qosEn,
	output logic sndQosReady,
	output logic nResOut,
	output logic aoutOe,
	output logic nBrIob
);

	syncT sync; // synchronized pins
	tickT tick;
	cfgT cfg;
	statusT status;
	logic [1:0] startState;

	syncEdge uSync (.CLK, .rstN, .e, .c8m, .nIpl2, .nResIn, .sync);

	refreshTimer #(.TimerWidth(TimerWidth), .LTimerWidth(LTimerWidth)) uRefresh (
		.CLK, .rstN, .sync, .cfg, .refReq, .refUrg, .tick
	);

	qosTimer #(.TimerWidth(TimerWidth)) uQos (
		.CLK, .rstN, .sync, .tick, .cfg, .bact, .qosCs, .sndQosCs, .qosEn, .sndQosReady
	);

	startupCtrl uStartup (
		.CLK, .rstN, .sync, .tick, .startState, .nResOut, .aoutOe, .nBrIob
	);

	cfgRegs #(.TimerWidth(TimerWidth), .LTimerWidth(LTimerWidth)) uRegs (
		.CLK, .rstN, .axiReq, .axiRsp, .status, .cfg
	);

	assign status = '{
		startState: startState,
		refReq: refReq,
		refUrg: refUrg,
		qosEn: qosEn,
		sndQosReady: sndQosReady,
		nResOut: nResOut,
		clkOk: sync.clkOk // C8M health
	};

endmodule

/* accelCnt_properties.sv */
`timescale 1ns/1ps

module accelCnt_properties (
	input  logic CLK,
	input  logic rstN,
	input  logic [1:0] state,
	input  logic aoutOe,
	input  logic bvalid,
	input  logic bready
);

	// power-up order HOLD0, HOLD1, ARB, RUN; any state may fall back to HOLD0
	stateStep: assert property (@(posedge CLK) disable iff (!rstN)
		(state != $past(state)) |-> (state == 2'($past(state) + 2'd1) || state == 2'd0))
		else $error("power-up state skipped a step");

	// output enable is registered from the state one cycle earlier
	oeOnlyInRun: assert property (@(posedge CLK) disable iff (!rstN)
		(state != 2'd3) |=> !aoutOe)
		else $error("aoutOe high outside RUN");

	bvalidHold: assert property (@(posedge CLK) disable iff (!rstN)
		(bvalid && !bready) |=> bvalid)
		else $error("bvalid dropped before bready");

endmodule

/* accelCnt_tb.sv */
`timescale 1ns/1ps

module accelCnt_tb import accelCntPkg::*; ();

	localparam int PeriodCycles = 20; // E period in clocks
	localparam int CheckDelay = 10; // clocks from E fall to compare
	localparam int MaxPeriods = 240;
	localparam int WatchdogNs = (MaxPeriods + 10) * PeriodCycles * 10 * 2;

	typedef struct packed {
		logic [3:0] timer;
		logic [11:0] lTimer;
		logic [3:0] qosCnt;
		logic [3:0] sndCnt;
		logic [1:0] state;
		logic nResOut;
		logic aoutOe;
		logic nBrIob;
		logic refReq;
		logic refUrg;
		logic clkOk;
		logic nIplLow; // NMI line held low
	} modelT;

	logic CLK;
	logic rstN;
	logic e;
	logic c8m;
	logic nIpl2;
	logic nResIn;
	logic bact;
	logic qosCs;
	logic sndQosCs;
	axiReqT axiReq;
	axiRspT axiRsp;
	logic refReq;
	logic refUrg;
	logic qosEn;
	logic sndQosReady;
	logic nResOut;
	logic aoutOe;
	logic nBrIob;

	logic c8mRun = 1'b1; // C8M source running
	int cyc = 0;
	integer seed = 79362;
	logic failShown = 1'b0;
	logic passed = 1'b0;
	modelT expM; // expected state after the latest E fall
	cfgT cfgM; // expected register contents
	event fallEv;

	accelCnt #(.TimerWidth(4), .LTimerWidth(12)) DUT (
		.CLK, .rstN, .e, .c8m, .nIpl2, .nResIn, .bact, .qosCs, .sndQosCs,
		.axiReq, .axiRsp, .refReq, .refUrg, .qosEn, .sndQosReady,
		.nResOut, .aoutOe, .nBrIob
	);

	bind startupCtrl accelCnt_properties uStartProps (
		.CLK(CLK), .rstN(rstN), .state(startState), .aoutOe(aoutOe),
		.bvalid(1'b0), .bready(1'b0)
	);
	bind cfgRegs accelCnt_properties uRegProps (
		.CLK(CLK), .rstN(rstN), .state(2'b00), .aoutOe(1'b0),
		.bvalid(axiRsp.bvalid), .bready(axiReq.bready)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK; // 10 ns period
	end

	always @(posedge CLK) cyc <= cyc + 1;

	initial begin
		forever begin
			repeat (2) @(negedge CLK);
			if (c8mRun)
				c8m = ~c8m; // C8M period of four clocks
		end
	end

	//////////////////////////////
	// failure reporting
	//////////////////////////////

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, want);
		failShown = 1'b1;
		$display("Simulation failed");
		$fatal(1, "value mismatch");
	endtask

	task automatic reportError(input string msg);
		$display("%s", msg);
		failShown = 1'b1;
		$display("Simulation failed");
		$fatal(1, "test aborted");
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] want);
		assert (got === want)
		else reportMismatch(name, got, want);
	endtask

	//////////////////////////////
	// reference model
	//////////////////////////////

	// output rules of the power-up sequence for the current state
	function automatic modelT settle(modelT m);
		modelT n;
		n = m;
		if (!n.clkOk)
			n.state = 2'd0; // clock lost forces HOLD0
		if (n.state == 2'd3)
			n.aoutOe = !n.nBrIob;
		else begin
			n.nResOut = 1'b0;
			n.aoutOe = 1'b0;
			if (n.state != 2'd2)
				n.nBrIob = 1'b0; // bus requested while holding
			else if (n.nIplLow)
				n.nBrIob = 1'b1; // NMI in ARB
		end
		return n;
	endfunction

	function automatic modelT expectAfterFall(modelT m, cfgT c);
		modelT n;
		logic wrap;
		logic lWrap;
		n = m;
		wrap = m.timer == c.refPeriod;
		n.refReq = !wrap; // idle step at the period end
		n.refUrg = (m.timer >= c.urgStart) && (m.timer < c.refPeriod);
		n.timer = wrap ? 4'd0 : m.timer + 4'd1;
		if (wrap) begin
			if (m.qosCnt != 4'd0)
				n.qosCnt = m.qosCnt - 4'd1;
			if (m.sndCnt != 4'd0)
				n.sndCnt = m.sndCnt - 4'd1;
			lWrap = m.lTimer == c.lTimerLen;
			n.lTimer = lWrap ? 12'd0 : m.lTimer + 12'd1;
			if (lWrap && m.clkOk) begin
				if (m.state == 2'd3)
					n.nResOut = 1'b1; // release a long tick after RUN
				else if (m.state != 2'd2 || !m.nIplLow)
					n.state = m.state + 2'd1;
			end
		end
		return settle(n);
	endfunction

	function automatic statusT statusOf(modelT m);
		statusT s;
		s.startState = m.state;
		s.refReq = m.refReq;
		s.refUrg = m.refUrg;
		s.qosEn = m.qosCnt != 4'd0;
		s.sndQosReady = m.sndCnt == 4'd0;
		s.nResOut = m.nResOut;
		s.clkOk = m.clkOk;
		return s;
	endfunction

	//////////////////////////////
	// AXI4-Lite and bus stimulus
	//////////////////////////////

	task automatic writeReg(input logic [3:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input logic [1:0] wantResp);
		int waitCnt;
		axiReq.awaddr = addr;
		axiReq.wdata = data;
		axiReq.wstrb = strb;
		axiReq.awvalid = 1'b1;
		axiReq.wvalid = 1'b1;
		waitCnt = 0;
		#1;
		while (!axiRsp.awready) begin
			@(negedge CLK);
			#1;
			waitCnt++;
			if (waitCnt > 16)
				reportError("AXI write address was never accepted");
		end
		checkValue("wready", 32'(axiRsp.wready), 32'd1); // pulses with awready
		@(negedge CLK);
		axiReq.awvalid = 1'b0;
		axiReq.wvalid = 1'b0;
		axiReq.bready = 1'b1;
		waitCnt = 0;
		while (!axiRsp.bvalid) begin
			@(negedge CLK);
			waitCnt++;
			if (waitCnt > 16)
				reportError("AXI write response never arrived");
		end
		checkValue("bresp", 32'(axiRsp.bresp), 32'(wantResp));
		@(negedge CLK);
		axiReq.bready = 1'b0;
	endtask

	task automatic readReg(input logic [3:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int waitCnt;
		axiReq.araddr = addr;
		axiReq.arvalid = 1'b1;
		waitCnt = 0;
		#1;
		while (!axiRsp.arready) begin
			@(negedge CLK);
			#1;
			waitCnt++;
			if (waitCnt > 16)
				reportError("AXI read address was never accepted");
		end
		@(negedge CLK);
		axiReq.arvalid = 1'b0;
		axiReq.rready = 1'b1;
		waitCnt = 0;
		while (!axiRsp.rvalid) begin
			@(negedge CLK);
			waitCnt++;
			if (waitCnt > 16)
				reportError("AXI read data never arrived");
		end
		data = axiRsp.rdata;
		resp = axiRsp.rresp;
		@(negedge CLK);
		axiReq.rready = 1'b0;
	endtask

	task automatic expectRead(input string name, input logic [3:0] addr,
		input logic [31:0] wantData, input logic [1:0] wantResp);
		logic [31:0] data;
		logic [1:0] resp;
		readReg(addr, data, resp);
		checkValue("rresp", 32'(resp), 32'(wantResp));
		checkValue(name, data, wantData);
	endtask

	// one bus cycle, kind 0 unselected, 1 QoS select, 2 sound select
	task automatic busAccess(input int kind, input int len);
		bact = 1'b1;
		qosCs = kind == 1;
		sndQosCs = kind == 2;
		repeat (len) @(negedge CLK);
		bact = 1'b0;
		qosCs = 1'b0;
		sndQosCs = 1'b0;
		if (kind != 0) begin
			expM.qosCnt = cfgM.qosLen;
			expM.sndCnt = (kind == 2) ? {2'b00, cfgM.sndQosLen} : 4'd0;
		end
	endtask

	//////////////////////////////
	// compare process
	//////////////////////////////

	initial begin : compare
		modelT want;
		forever begin
			@(fallEv);
			want = expM; // snapshot for this E fall
			repeat (CheckDelay) @(negedge CLK);
			checkValue("refReq", 32'(refReq), 32'(want.refReq));
			checkValue("refUrg", 32'(refUrg), 32'(want.refUrg));
			checkValue("qosEn", 32'(qosEn), 32'(want.qosCnt != 4'd0));
			checkValue("sndQosReady", 32'(sndQosReady), 32'(want.sndCnt == 4'd0));
			checkValue("nResOut", 32'(nResOut), 32'(want.nResOut));
			checkValue("aoutOe", 32'(aoutOe), 32'(want.aoutOe));
			checkValue("nBrIob", 32'(nBrIob), 32'(want.nBrIob));
		end
	end

	initial begin
		#(WatchdogNs);
		reportError("watchdog expired before the test sequence finished");
	end

	final begin
		if (!passed && !failShown)
			$display("Simulation failed"); // stopped by a bound assertion
	end

	//////////////////////////////
	// main stimulus
	//////////////////////////////

	initial begin : stimulus
		int p;
		int startCyc;
		int stage;
		int holdStart;
		int kind;
		logic done;
		rstN = 1'b0;
		e = 1'b1; // first fall only after reset
		c8m = 1'b0;
		nIpl2 = 1'b1;
		nResIn = 1'b1;
		bact = 1'b0;
		qosCs = 1'b0;
		sndQosCs = 1'b0;
		axiReq = '0;
		cfgM = '{refPeriod: 4'd10, urgStart: 4'd8, qosLen: 4'd15, sndQosLen: 2'd3,
			lTimerLen: 12'd4095};
		expM = '0;
		expM.clkOk = 1'b1;
		stage = 0;
		holdStart = 0;
		done = 1'b0;
		repeat (5) @(negedge CLK);
		rstN = 1'b1;
		repeat (4) @(negedge CLK);
		for (p = 0; p < MaxPeriods && !done; p++) begin
			e = 1'b0; // E falls
			startCyc = cyc;
			expM = expectAfterFall(expM, cfgM);
			-> fallEv;
			repeat (CheckDelay) @(negedge CLK);
			e = 1'b1;
			if (p == 0) begin
				writeReg(ADDR_LTIM, 32'h2, 4'hF, RESP_OKAY); // short long timer
				cfgM.lTimerLen = 12'd2;
			end else if (p == 1)
				expectRead("lTimerLen", ADDR_LTIM, 32'h2, RESP_OKAY);
			else if (p == 22) begin
				writeReg(ADDR_REF, 32'h35, 4'hF, RESP_OKAY); // period 5, urgent from 3
				cfgM.refPeriod = 4'd5;
				cfgM.urgStart = 4'd3;
			end else if (p == 23)
				expectRead("refCfg", ADDR_REF, 32'h35, RESP_OKAY);
			else if (p == 24)
				writeReg(ADDR_STAT, 32'hFF, 4'hF, RESP_SLVERR);
			else if (p == 25)
				expectRead("unused", 4'h2, 32'h0, RESP_SLVERR);
			else if (p == 26) begin
				writeReg(ADDR_QOS, 32'h23, 4'hF, RESP_OKAY);
				cfgM.qosLen = 4'd3;
				cfgM.sndQosLen = 2'd2;
			end else if (p == 27)
				expectRead("qosCfg", ADDR_QOS, 32'h23, RESP_OKAY);
			else if (p < 60) begin
				kind = int'({$random(seed)} % 32'd3);
				if (p == 28)
					kind = 1;
				if (p == 59)
					kind = 2; // sound hold runs out in the quiet part
				busAccess(kind, 2 + int'({$random(seed)} % 32'd4));
			end else if (stage == 0 && expM.state == 2'd3 && expM.nResOut) begin
				c8mRun = 1'b0; // stop C8M
				expM.clkOk = 1'b0;
				expM = settle(expM);
				stage = 1;
			end else if (stage == 1) begin
				expectRead("status", ADDR_STAT, {24'd0, statusOf(expM)}, RESP_OKAY);
				stage = 2;
			end else if (stage == 2) begin
				c8mRun = 1'b1; // restart C8M
				expM.clkOk = 1'b1;
				stage = 3;
			end else if (stage == 3 && expM.state == 2'd2) begin
				nIpl2 = 1'b0; // NMI during ARB
				expM.nIplLow = 1'b1;
				expM = settle(expM);
				holdStart = p;
				stage = 4;
			end else if (stage == 4 && p - holdStart == PeriodCycles) begin
				nIpl2 = 1'b1;
				expM.nIplLow = 1'b0;
				stage = 5;
			end else if (stage == 5 && expM.state == 2'd3 && expM.nResOut)
				done = 1'b1;
			else
				expectRead("status", ADDR_STAT, {24'd0, statusOf(expM)}, RESP_OKAY);
			while (cyc - startCyc < PeriodCycles)
				@(negedge CLK);
		end
		assert (done)
		else reportError("power-up sequence did not finish within the run");
		passed = 1'b1;
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* accelCnt.f */
accelCntPkg.sv
syncEdge.sv
refreshTimer.sv
qosTimer.sv
startupCtrl.sv
cfgRegs.sv
accelCnt.sv
accelCnt_properties.sv
accelCnt_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module accelCnt_tb -f accelCnt.f

out=$(./obj_dir/VaccelCnt_tb) || true
echo "$out"

echo "$out" | grep -q "Simulation completed successfully"
